//--- noc_pkg.sv
package noc_pkg;

  // ==================================================
  // Sizes
  // ==================================================
  localparam int flit_data_width    = 64;
  localparam int vc_count           = 2;
  localparam int link_buffer_depth  = 4;
  localparam int id_width           = 4;
  localparam int tag_width          = 4;
  localparam int burst_length_width = 4;
  localparam int address_width      = 32;
  localparam int data_width         = 32;
  localparam int byte_enable_width  = data_width / 8;
  localparam int status_width       = 2;
  localparam int packet_type_width  = 3;
  localparam int vc_width           = $clog2(vc_count);
  localparam int max_burst_beats    = 16;

  // Padding that fills each view out to one flit data word
  localparam int request_pad_width  = flit_data_width - (packet_type_width + 2 * id_width +
                                      vc_width + tag_width + burst_length_width + address_width);
  localparam int response_pad_width = flit_data_width - (packet_type_width + 2 * id_width +
                                      vc_width + tag_width + status_width);
  localparam int write_pad_width    = flit_data_width - (data_width + byte_enable_width);
  localparam int read_pad_width     = flit_data_width - (data_width + status_width + 1);

  typedef logic [vc_width-1:0]                        vc_t;
  typedef logic [$clog2(link_buffer_depth + 1)-1:0]   credit_t;
  typedef logic [id_width-1:0]                        node_id_t;
  typedef logic [tag_width-1:0]                       tag_t;
  typedef logic [burst_length_width-1:0]              burst_length_t;
  typedef logic [address_width-1:0]                   address_t;
  typedef logic [data_width-1:0]                      data_t;
  typedef logic [byte_enable_width-1:0]               byte_enable_t;
  typedef logic [status_width-1:0]                    status_t;
  typedef logic [$clog2(max_burst_beats):0]           beat_count_t;

  // ==================================================
  // Encodings
  // ==================================================
  typedef enum logic [packet_type_width-1:0] {
    read_request   = 3'b000,
    write_request  = 3'b001,
    posted_write   = 3'b010,
    read_response  = 3'b100,
    write_response = 3'b101
  } packet_type_t;

  typedef enum logic {
    header_flit  = 1'b0,
    payload_flit = 1'b1
  } flit_type_t;

  typedef enum logic {
    write_beat = 1'b0,
    read_beat  = 1'b1
  } payload_kind_t;

  // ==================================================
  // Flit data views
  // ==================================================
  typedef struct packed {
    logic [request_pad_width-1:0] pad;
    packet_type_t                 packet_type;
    node_id_t                     destination_id;
    node_id_t                     source_id;
    vc_t                          vc;
    tag_t                         tag;
    burst_length_t                burst_length;
    address_t                     address;
  } request_header_t;

  typedef struct packed {
    logic [response_pad_width-1:0] pad;
    packet_type_t                  packet_type;
    node_id_t                      destination_id;
    node_id_t                      source_id;
    vc_t                           vc;
    tag_t                          tag;
    status_t                       status;
  } response_header_t;

  typedef struct packed {
    logic [write_pad_width-1:0] pad;
    data_t                      data;
    byte_enable_t               byte_enable;
  } write_payload_t;

  typedef struct packed {
    logic [read_pad_width-1:0] pad;
    data_t                     data;
    status_t                   status;
    logic                      response_last;
  } read_payload_t;

  // Flit type and packet type select the view
  typedef union packed {
    request_header_t  req_header;
    response_header_t rsp_header;
    write_payload_t   write_payload;
    read_payload_t    read_payload;
  } flit_data_u;

  typedef struct packed {
    flit_type_t flit_type;
    logic       head;
    logic       tail;
    flit_data_u data;
  } flit_t;

  // ==================================================
  // Packet input side
  // ==================================================
  typedef struct packed {
    packet_type_t  packet_type;
    node_id_t      destination_id;
    node_id_t      source_id;
    vc_t           vc;
    tag_t          tag;
    burst_length_t burst_length;
    address_t      address;
    status_t       status;
  } packet_header_t;

  typedef struct packed {
    payload_kind_t kind;
    data_t         data;
    byte_enable_t  byte_enable;
    status_t       status;
    logic          response_last;
    logic          last;
  } packet_payload_t;

  function automatic logic is_request(input packet_type_t packet_type);
    return packet_type inside {read_request, write_request, posted_write};
  endfunction

  function automatic logic has_payload(input packet_type_t packet_type);
    return packet_type inside {write_request, read_response};
  endfunction

endpackage

//--- header_flit_builder.sv
`timescale 1ns/1ps

module header_flit_builder
  import noc_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           header_valid,
  output logic           header_ready,
  input  packet_header_t header,
  output logic           hdr_flit_valid,
  output flit_t          header_flit,
  output vc_t            header_flit_vc,
  input  logic           hdr_flit_take
);

  request_header_t  req_view;
  response_header_t rsp_view;
  flit_t            next_flit;
  logic             accept;
  logic             full;
  flit_t            flit_q;
  vc_t              vc_q;

  // ==================================================
  // Header packing
  // ==================================================
  assign req_view = '{
    pad:            '0,
    packet_type:    header.packet_type,
    destination_id: header.destination_id,
    source_id:      header.source_id,
    vc:             header.vc,
    tag:            header.tag,
    burst_length:   header.burst_length,
    address:        header.address
  };

  assign rsp_view = '{
    pad:            '0,
    packet_type:    header.packet_type,
    destination_id: header.destination_id,
    source_id:      header.source_id,
    vc:             header.vc,
    tag:            header.tag,
    status:         header.status
  };

  always_comb begin
    // Enum value from the package, the port shares this name
    next_flit.flit_type = noc_pkg::header_flit;
    next_flit.head      = 1'b1;
    next_flit.tail      = !has_payload(header.packet_type);
    if (is_request(header.packet_type)) begin
      next_flit.data.req_header = req_view;
    end else begin
      next_flit.data.rsp_header = rsp_view;
    end
  end

  // ==================================================
  // One-entry buffer
  // ==================================================
  // Take frees the slot in the same cycle
  assign header_ready = !full || hdr_flit_take;
  assign accept       = header_valid && header_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (hdr_flit_take) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      flit_q <= next_flit;
      vc_q   <= header.vc;
    end
  end

  assign hdr_flit_valid = full;
  assign header_flit    = flit_q;
  assign header_flit_vc = vc_q;

  // Sequencer only takes a flit that is held here
  a_take_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) hdr_flit_take |-> full
  );

endmodule

//--- payload_flit_builder.sv
`timescale 1ns/1ps

module payload_flit_builder
  import noc_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            payload_valid,
  output logic            payload_ready,
  input  packet_payload_t payload,
  output logic            pay_flit_valid,
  output flit_t           payload_flit,
  input  logic            pay_flit_take
);

  write_payload_t write_view;
  read_payload_t  read_view;
  flit_t          next_flit;
  logic           accept;
  logic           full;
  flit_t          flit_q;
  beat_count_t    beat_count;

  // ==================================================
  // Beat packing
  // ==================================================
  assign write_view = '{
    pad:         '0,
    data:        payload.data,
    byte_enable: payload.byte_enable
  };

  assign read_view = '{
    pad:           '0,
    data:          payload.data,
    status:        payload.status,
    response_last: payload.response_last
  };

  always_comb begin
    next_flit.flit_type = noc_pkg::payload_flit;
    next_flit.head      = 1'b0;
    next_flit.tail      = payload.last;
    if (payload.kind == write_beat) begin
      next_flit.data.write_payload = write_view;
    end else begin
      next_flit.data.read_payload = read_view;
    end
  end

  // ==================================================
  // One-entry buffer
  // ==================================================
  assign payload_ready = !full || pay_flit_take;
  assign accept        = payload_valid && payload_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (pay_flit_take) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      flit_q <= next_flit;
    end
  end

  assign pay_flit_valid = full;
  assign payload_flit   = flit_q;

  // Beats accepted since the last tail
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_count <= '0;
    end else if (accept) begin
      beat_count <= payload.last ? beat_count_t'(0) : beat_count + 1'b1;
    end
  end

  a_burst_limit: assert property (
    @(posedge clk) disable iff (!rst_n) accept |-> (beat_count < max_burst_beats)
  );

endmodule

//--- flit_sequencer.sv
`timescale 1ns/1ps

module flit_sequencer
  import noc_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                hdr_flit_valid,
  input  flit_t               header_flit,
  input  vc_t                 header_flit_vc,
  output logic                hdr_flit_take,
  input  logic                pay_flit_valid,
  input  flit_t               payload_flit,
  output logic                pay_flit_take,
  output logic                flit_valid,
  output flit_t               flit,
  output vc_t                 flit_vc,
  input  logic [vc_count-1:0] credit_return
);

  typedef enum logic {
    header_phase  = 1'b0,
    payload_phase = 1'b1
  } seq_state_t;

  seq_state_t                state;
  vc_t                       payload_vc;
  logic                      cand_valid;
  logic                      has_credit;
  credit_t [vc_count-1:0]    credit;

  // ==================================================
  // Flit selection
  // ==================================================
  always_comb begin
    if (state == header_phase) begin
      cand_valid = hdr_flit_valid;
      flit       = header_flit;
      flit_vc    = header_flit_vc;
    end else begin
      cand_valid = pay_flit_valid;
      flit       = payload_flit;
      flit_vc    = payload_vc;
    end
  end

  assign has_credit = (credit[flit_vc] != '0);

  // Send and take in the same cycle
  assign flit_valid    = cand_valid && has_credit;
  assign hdr_flit_take = flit_valid && (state == header_phase);
  assign pay_flit_take = flit_valid && (state == payload_phase);

  // ==================================================
  // Packet phase
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= header_phase;
      payload_vc <= '0;
    end else if (flit_valid) begin
      if (flit.tail) begin
        state <= header_phase;
      end else if (state == header_phase) begin
        // Payload follows on the header's VC
        state      <= payload_phase;
        payload_vc <= header_flit_vc;
      end
    end
  end

  // ==================================================
  // Credits per VC
  // ==================================================
  for (genvar v = 0; v < vc_count; v++) begin : g_credit
    logic consume;

    assign consume = flit_valid && (flit_vc == vc_t'(v));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        credit[v] <= credit_t'(link_buffer_depth);
      end else begin
        case ({consume, credit_return[v]})
          2'b10:   credit[v] <= credit[v] - 1'b1;
          2'b01:   credit[v] <= credit[v] + 1'b1;
          default: credit[v] <= credit[v];
        endcase
      end
    end

    // Receiver never returns more than it was sent
    a_credit_bound: assert property (
      @(posedge clk) disable iff (!rst_n) credit[v] <= link_buffer_depth
    );
  end

endmodule

//--- noc_packet_packer.sv
`timescale 1ns/1ps

module noc_packet_packer
  import noc_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                header_valid,
  output logic                header_ready,
  input  packet_header_t      header,
  input  logic                payload_valid,
  output logic                payload_ready,
  input  packet_payload_t     payload,
  output logic                flit_valid,
  output flit_t               flit,
  output vc_t                 flit_vc,
  input  logic [vc_count-1:0] credit_return
);

  logic  hdr_flit_valid;
  flit_t header_flit;
  vc_t   header_flit_vc;
  logic  hdr_flit_take;
  logic  pay_flit_valid;
  flit_t payload_flit;
  logic  pay_flit_take;

  header_flit_builder u_header_flit_builder (
    .clk            (clk),
    .rst_n          (rst_n),
    .header_valid   (header_valid),
    .header_ready   (header_ready),
    .header         (header),
    .hdr_flit_valid (hdr_flit_valid),
    .header_flit    (header_flit),
    .header_flit_vc (header_flit_vc),
    .hdr_flit_take  (hdr_flit_take)
  );

  payload_flit_builder u_payload_flit_builder (
    .clk            (clk),
    .rst_n          (rst_n),
    .payload_valid  (payload_valid),
    .payload_ready  (payload_ready),
    .payload        (payload),
    .pay_flit_valid (pay_flit_valid),
    .payload_flit   (payload_flit),
    .pay_flit_take  (pay_flit_take)
  );

  flit_sequencer u_flit_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .hdr_flit_valid (hdr_flit_valid),
    .header_flit    (header_flit),
    .header_flit_vc (header_flit_vc),
    .hdr_flit_take  (hdr_flit_take),
    .pay_flit_valid (pay_flit_valid),
    .payload_flit   (payload_flit),
    .pay_flit_take  (pay_flit_take),
    .flit_valid     (flit_valid),
    .flit           (flit),
    .flit_vc        (flit_vc),
    .credit_return  (credit_return)
  );

endmodule

//--- tb_noc_packer.sv
`timescale 1ns/1ps

module tb_noc_packer
  import noc_pkg::*;
();

  localparam int num_packets      = 60;
  localparam int clk_period       = 20;
  localparam int settle_delay     = 5;
  localparam int max_gap          = 4;
  localparam int max_credit_delay = 12;
  localparam int hold_start       = 80;
  localparam int hold_length      = 120;
  localparam int timeout_cycles   = num_packets * (5 + 20) + 200;

  logic                clk;
  logic                rst_n;
  logic                header_valid;
  logic                header_ready;
  packet_header_t      header;
  logic                payload_valid;
  logic                payload_ready;
  packet_payload_t     payload;
  logic                flit_valid;
  flit_t               flit;
  vc_t                 flit_vc;
  logic [vc_count-1:0] credit_return;

  integer      seed = 32'hec644ee8;
  int unsigned cycle_count;
  int unsigned flits_seen;
  int unsigned total_flits;
  logic        credits_held;
  logic        in_packet;
  vc_t         packet_vc;
  logic        headers_done;
  logic        beats_done;

  packet_header_t  header_list[num_packets];
  int unsigned     header_gap[num_packets];
  packet_payload_t beat_list[$];
  int unsigned     beat_gap[$];
  flit_t           expect_flit[$];
  vc_t             expect_vc[$];
  int unsigned     credit_delay[$];

  // Receiver buffer model, one ring of return times per VC
  int unsigned occupancy[vc_count];
  int unsigned return_head[vc_count];
  int unsigned return_due[vc_count][link_buffer_depth];

  noc_packet_packer uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .header_valid  (header_valid),
    .header_ready  (header_ready),
    .header        (header),
    .payload_valid (payload_valid),
    .payload_ready (payload_ready),
    .payload       (payload),
    .flit_valid    (flit_valid),
    .flit          (flit),
    .flit_vc       (flit_vc),
    .credit_return (credit_return)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ==================================================
  // Helpers
  // ==================================================
  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Run stopped at cycle %0d", cycle_count);
  endtask

  task automatic describe_error(input string what);
    $display("ERROR %s (cycle %0d)", what, cycle_count);
    abort_run();
  endtask

  task automatic show_mismatch(input string test, input logic [$bits(flit_t)-1:0] expected,
                               input logic [$bits(flit_t)-1:0] actual);
    $display("MISMATCH %s expected %h actual %h", test, expected, actual);
    abort_run();
  endtask

  // Random packets and the flits they must turn into
  task automatic build_packets();
    packet_header_t  h;
    packet_payload_t b;
    flit_t           f;
    packet_type_t    ptype;
    logic            req;
    logic            with_payload;
    int unsigned     beats;
    for (int i = 0; i < num_packets; i++) begin
      case (rand_below(5))
        0:       ptype = read_request;
        1:       ptype = write_request;
        2:       ptype = posted_write;
        3:       ptype = read_response;
        default: ptype = write_response;
      endcase
      req = (ptype == read_request) || (ptype == write_request) ||
            (ptype == posted_write);
      with_payload     = (ptype == write_request) || (ptype == read_response);
      beats            = with_payload ? 1 + rand_below(4) : 0;
      h.packet_type    = ptype;
      h.destination_id = node_id_t'(rand_below(16));
      h.source_id      = node_id_t'(rand_below(16));
      h.vc             = vc_t'(rand_below(vc_count));
      h.tag            = tag_t'(rand_below(16));
      h.burst_length   = burst_length_t'(beats);
      h.address        = $random(seed);
      h.status         = status_t'(rand_below(4));
      header_list[i]   = h;
      header_gap[i]    = rand_below(max_gap);

      f           = '0;
      f.flit_type = header_flit;
      f.head      = 1'b1;
      f.tail      = !with_payload;
      if (req) begin
        f.data.req_header.packet_type    = ptype;
        f.data.req_header.destination_id = h.destination_id;
        f.data.req_header.source_id      = h.source_id;
        f.data.req_header.vc             = h.vc;
        f.data.req_header.tag            = h.tag;
        f.data.req_header.burst_length   = h.burst_length;
        f.data.req_header.address        = h.address;
      end else begin
        f.data.rsp_header.packet_type    = ptype;
        f.data.rsp_header.destination_id = h.destination_id;
        f.data.rsp_header.source_id      = h.source_id;
        f.data.rsp_header.vc             = h.vc;
        f.data.rsp_header.tag            = h.tag;
        f.data.rsp_header.status         = h.status;
      end
      expect_flit.push_back(f);
      expect_vc.push_back(h.vc);
      credit_delay.push_back(1 + rand_below(max_credit_delay));

      for (int k = 0; k < beats; k++) begin
        b.kind          = (ptype == write_request) ? write_beat : read_beat;
        b.data          = $random(seed);
        b.byte_enable   = byte_enable_t'(rand_below(16));
        b.status        = status_t'(rand_below(4));
        b.response_last = (k == beats - 1);
        b.last          = (k == beats - 1);
        beat_list.push_back(b);
        beat_gap.push_back(rand_below(max_gap));
        f           = '0;
        f.flit_type = payload_flit;
        f.tail      = b.last;
        if (b.kind == write_beat) begin
          f.data.write_payload.data        = b.data;
          f.data.write_payload.byte_enable = b.byte_enable;
        end else begin
          f.data.read_payload.data          = b.data;
          f.data.read_payload.status        = b.status;
          f.data.read_payload.response_last = b.response_last;
        end
        expect_flit.push_back(f);
        expect_vc.push_back(h.vc);
        credit_delay.push_back(1 + rand_below(max_credit_delay));
      end
    end
  endtask

  task automatic check_flit();
    flit_t       want;
    vc_t         want_vc;
    int unsigned slot;
    assert (expect_flit.size() != 0) else describe_error("flit sent after the last expected one");
    want    = expect_flit.pop_front();
    want_vc = expect_vc.pop_front();
    assert (flit === want) else show_mismatch("flit_content", want, flit);
    assert (flit_vc === want_vc) else show_mismatch("flit_vc", want_vc, flit_vc);
    if (flit.flit_type == payload_flit) begin
      assert (in_packet && flit_vc == packet_vc)
        else describe_error("payload flit not following its header on the same VC");
    end else begin
      assert (!in_packet) else describe_error("header flit inside an unfinished packet");
      packet_vc = flit_vc;
    end
    in_packet = !flit.tail;
    assert (occupancy[flit_vc] < link_buffer_depth)
      else describe_error("flit sent on a VC whose receive buffer is full");
    slot = (return_head[flit_vc] + occupancy[flit_vc]) % link_buffer_depth;
    return_due[flit_vc][slot] = cycle_count + credit_delay.pop_front();
    occupancy[flit_vc]++;
    flits_seen++;
  endtask

  // ==================================================
  // Input drivers
  // ==================================================
  initial begin : header_driver
    logic accepted;
    wait (rst_n === 1'b1);
    @(negedge clk);
    for (int i = 0; i < num_packets; i++) begin
      repeat (header_gap[i]) @(negedge clk);
      header_valid = 1'b1;
      header       = header_list[i];
      do begin
        #settle_delay;
        accepted = header_ready;
        @(negedge clk);
      end while (!accepted);
      header_valid = 1'b0;
    end
    headers_done = 1'b1;
  end

  initial begin : payload_driver
    logic accepted;
    wait (rst_n === 1'b1);
    @(negedge clk);
    for (int i = 0; i < beat_list.size(); i++) begin
      repeat (beat_gap[i]) @(negedge clk);
      payload_valid = 1'b1;
      payload       = beat_list[i];
      do begin
        #settle_delay;
        accepted = payload_ready;
        @(negedge clk);
      end while (!accepted);
      payload_valid = 1'b0;
    end
    beats_done = 1'b1;
  end

  // Receiver side, frees entries after their delay
  initial begin : link_model
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      for (int v = 0; v < vc_count; v++) begin
        credit_return[v] = 1'b0;
        if (!credits_held && occupancy[v] != 0 &&
            return_due[v][return_head[v]] <= cycle_count) begin
          credit_return[v] = 1'b1;
          return_head[v]   = (return_head[v] + 1) % link_buffer_depth;
          occupancy[v]--;
        end
      end
      #settle_delay;
      if (flit_valid) begin
        check_flit();
      end
    end
  end

  // ==================================================
  // Assertions
  // ==================================================
  a_reset_outputs: assert property (
    @(posedge clk) $rose(rst_n) |-> (!flit_valid && header_ready && payload_ready)
  ) else describe_error("outputs not in their reset state");

  a_flit_known: assert property (
    @(posedge clk) disable iff (!rst_n) flit_valid |-> !$isunknown({flit, flit_vc})
  ) else describe_error("link flit has unknown bits");

  a_head_on_header: assert property (
    @(posedge clk) disable iff (!rst_n)
      flit_valid |-> (flit.head == (flit.flit_type == header_flit))
  ) else describe_error("head bit does not match the flit type");

  initial begin : watchdog
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > timeout_cycles) begin
        describe_error($sformatf("timeout with %0d of %0d flits received",
                                 flits_seen, total_flits));
      end
    end
  end

  initial begin : main
    rst_n         = 1'b0;
    header_valid  = 1'b0;
    header        = '0;
    payload_valid = 1'b0;
    payload       = '0;
    credit_return = '0;
    credits_held  = 1'b0;
    in_packet     = 1'b0;
    packet_vc     = '0;
    flits_seen    = 0;
    headers_done  = 1'b0;
    beats_done    = 1'b0;
    for (int v = 0; v < vc_count; v++) begin
      occupancy[v]   = 0;
      return_head[v] = 0;
    end
    build_packets();
    total_flits = expect_flit.size();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Long credit stall in the middle of traffic
    repeat (hold_start) @(posedge clk);
    credits_held = 1'b1;
    repeat (hold_length) @(posedge clk);
    credits_held = 1'b0;

    // Both builders empty and nothing on the link
    wait (headers_done && beats_done);
    @(negedge clk);
    while (flit_valid || !header_ready || !payload_ready) begin
      @(negedge clk);
    end
    if (expect_flit.size() == 0 && !in_packet) begin
      $display("** PASS **");
      $finish;
    end else begin
      describe_error("expected flits left in the queue at the end of the run");
    end
  end

endmodule

//--- project.f
noc_pkg.sv
header_flit_builder.sv
payload_flit_builder.sv
flit_sequencer.sv
noc_packet_packer.sv
tb_noc_packer.sv
